// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_rv_core -Mdir obj_dir -f verilog.f
	-./obj_dir/Vtb_rv_core > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN = 64;
  localparam int NREG = 32;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef enum logic {
    UNIT_ALU,
    UNIT_BJP
  } unit_e;

  // lui just forwards op2
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
  } alu_op_e;

  typedef enum logic [3:0] {
    BJP_NONE, BJP_JAL, BJP_JALR, BJP_BEQ, BJP_BNE,
    BJP_BLT, BJP_BGE, BJP_BLTU, BJP_BGEU
  } bjp_op_e;

  typedef struct packed {
    unit_e   unit;
    alu_op_e alu_op;
    bjp_op_e bjp_op;
    logic    ebreak;
  } exu_info_t;

  // decode to execute
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] op1_jp;
    logic [XLEN-1:0] op2_jp;
    logic [4:0]      rd;
    logic            rd_wr;
    exu_info_t       info;
    logic            illegal;
  } dec_t;

  // execute to writeback
  typedef struct packed {
    logic [4:0]      rd;
    logic            rd_wr;
    logic [XLEN-1:0] data;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic            ebreak;
    logic            illegal;
  } wb_t;

endpackage

`default_nettype wire

// File: exu/rv_exu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exu import rv_pkg::*; (
  input  dec_t dec_i,
  input  logic valid_i,
  output wb_t  wb_o
);

  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] jp_sum;
  logic [5:0]      shamt;
  logic            taken;

  assign op1   = dec_i.op1;
  assign op2   = dec_i.op2;
  assign shamt = op2[5:0];

  always_comb begin
    case (dec_i.info.alu_op)
      ALU_ADD:  alu_res = op1 + op2;
      ALU_SUB:  alu_res = op1 - op2;
      ALU_SLL:  alu_res = op1 << shamt;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op1 < op2};
      ALU_XOR:  alu_res = op1 ^ op2;
      ALU_SRL:  alu_res = op1 >> shamt;
      ALU_SRA:  alu_res = $signed(op1) >>> shamt;
      ALU_OR:   alu_res = op1 | op2;
      ALU_LUI:  alu_res = op2;
      default:  alu_res = op1 & op2;
    endcase
  end

  // branch compares use the same operand pair as the alu
  always_comb begin
    case (dec_i.info.bjp_op)
      BJP_JAL,
      BJP_JALR: taken = 1'b1;
      BJP_BEQ:  taken = op1 == op2;
      BJP_BNE:  taken = op1 != op2;
      BJP_BLT:  taken = $signed(op1) < $signed(op2);
      BJP_BGE:  taken = $signed(op1) >= $signed(op2);
      BJP_BLTU: taken = op1 < op2;
      BJP_BGEU: taken = op1 >= op2;
      default:  taken = 1'b0;
    endcase
  end

  assign jp_sum = dec_i.op1_jp + dec_i.op2_jp;

  assign wb_o.rd       = dec_i.rd;
  assign wb_o.rd_wr    = dec_i.rd_wr;
  // jumps carry alu_op add, giving pc + 4 here
  assign wb_o.data     = alu_res;
  assign wb_o.redirect = valid_i && (dec_i.info.unit == UNIT_BJP) && taken;
  assign wb_o.ebreak   = dec_i.info.ebreak;
  assign wb_o.illegal  = dec_i.illegal;

  // jalr target has bit 0 forced low
  assign wb_o.redirect_pc = (dec_i.info.bjp_op == BJP_JALR) ? {jp_sum[XLEN-1:1], 1'b0}
                                                             : jp_sum;

endmodule

`default_nettype wire

// File: idu/rv_idu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_idu import rv_pkg::*; (
  input  logic [31:0]     inst_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  output logic [4:0]      rs1_idx_o,
  output logic [4:0]      rs2_idx_o,
  output logic            rs1_rd_en_o,
  output logic            rs2_rd_en_o,
  output dec_t            dec_o
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [4:0]      rd;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm;
  logic            legal;
  logic            use_rs1;
  logic            use_rs2;
  logic            writes_rd;
  logic            is_bjp;
  logic            is_ebreak;
  logic            op1_pc;
  logic            op2_imm;
  logic            op2_four;
  alu_op_e         alu_op;
  bjp_op_e         bjp_op;

  // shared by OP and OP-IMM, alt selects sub/sra
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign rd     = inst_i[11:7];

  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_b = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    legal     = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    writes_rd = 1'b0;
    is_bjp    = 1'b0;
    is_ebreak = 1'b0;
    op1_pc    = 1'b0;
    op2_imm   = 1'b0;
    op2_four  = 1'b0;
    imm       = imm_i;
    alu_op    = ALU_ADD;
    bjp_op    = BJP_NONE;
    case (opcode)
      OPC_OP: begin
        legal     = (inst_i[31:25] == 7'h00) ||
                    (inst_i[31:25] == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        writes_rd = 1'b1;
        alu_op    = alu_from_f3(funct3, inst_i[30]);
      end
      OPC_OP_IMM: begin
        // rv64 shifts take a 6-bit shamt, so only inst[31:26] is checked
        case (funct3)
          3'b001:  legal = inst_i[31:26] == 6'b000000;
          3'b101:  legal = inst_i[31:26] == 6'b000000 || inst_i[31:26] == 6'b010000;
          default: legal = 1'b1;
        endcase
        use_rs1   = 1'b1;
        writes_rd = 1'b1;
        op2_imm   = 1'b1;
        alu_op    = alu_from_f3(funct3, funct3 == 3'b101 && inst_i[30]);
      end
      OPC_BRANCH: begin
        legal   = funct3[2:1] != 2'b01;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        is_bjp  = 1'b1;
        imm     = imm_b;
        case (funct3)
          3'b000:  bjp_op = BJP_BEQ;
          3'b001:  bjp_op = BJP_BNE;
          3'b100:  bjp_op = BJP_BLT;
          3'b101:  bjp_op = BJP_BGE;
          3'b110:  bjp_op = BJP_BLTU;
          3'b111:  bjp_op = BJP_BGEU;
          default: bjp_op = BJP_NONE;
        endcase
      end
      OPC_JAL: begin
        legal     = 1'b1;
        writes_rd = 1'b1;
        is_bjp    = 1'b1;
        op1_pc    = 1'b1;
        op2_four  = 1'b1;
        imm       = imm_j;
        bjp_op    = BJP_JAL;
      end
      OPC_JALR: begin
        legal     = funct3 == 3'b000;
        use_rs1   = 1'b1;
        writes_rd = 1'b1;
        is_bjp    = 1'b1;
        op1_pc    = 1'b1;
        op2_four  = 1'b1;
        bjp_op    = BJP_JALR;
      end
      OPC_LUI: begin
        legal     = 1'b1;
        writes_rd = 1'b1;
        op2_imm   = 1'b1;
        imm       = imm_u;
        alu_op    = ALU_LUI;
      end
      OPC_AUIPC: begin
        legal     = 1'b1;
        writes_rd = 1'b1;
        op1_pc    = 1'b1;
        op2_imm   = 1'b1;
        imm       = imm_u;
      end
      OPC_SYSTEM: begin
        // ebreak only, ecall and csr ops are not supported
        legal     = inst_i[31:7] == {12'h001, 13'h0000};
        is_ebreak = legal;
      end
      default: legal = 1'b0;
    endcase
  end

  assign rs1_idx_o   = inst_i[19:15];
  assign rs2_idx_o   = inst_i[24:20];
  assign rs1_rd_en_o = legal & use_rs1;
  assign rs2_rd_en_o = legal & use_rs2;

  // link address for jumps is pc + 4 through the alu
  assign dec_o.pc      = pc_i;
  assign dec_o.op1     = op1_pc ? pc_i : rs1_data_i;
  assign dec_o.op2     = op2_four ? XLEN'(4) : (op2_imm ? imm : rs2_data_i);
  assign dec_o.op1_jp  = (bjp_op == BJP_JALR) ? rs1_data_i : pc_i;
  assign dec_o.op2_jp  = imm;
  assign dec_o.rd      = rd;
  assign dec_o.rd_wr   = legal & writes_rd & (rd != 5'd0);
  assign dec_o.illegal = ~legal;

  // illegal encodings leave a harmless add in the info field
  assign dec_o.info.unit   = (legal & is_bjp) ? UNIT_BJP : UNIT_ALU;
  assign dec_o.info.alu_op = legal ? alu_op : ALU_ADD;
  assign dec_o.info.bjp_op = legal ? bjp_op : BJP_NONE;
  assign dec_o.info.ebreak = is_ebreak;

endmodule

`default_nettype wire

// File: rtl/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            inst_valid_i,
  input  logic [31:0]     inst_i,
  input  logic [XLEN-1:0] pc_i,
  output logic            wb_valid_o,
  output logic [4:0]      wb_rd_o,
  output logic            wb_wr_o,
  output logic [XLEN-1:0] wb_data_o,
  output logic            redirect_o,
  output logic [XLEN-1:0] redirect_pc_o,
  output logic            ebreak_o,
  output logic            illegal_o
);

  logic [4:0]      rs1_idx;
  logic [4:0]      rs2_idx;
  logic            rs1_rd_en;
  logic            rs2_rd_en;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  dec_t            dec_d;
  dec_t            dec_e;
  logic            d2e_valid;
  wb_t             wb_e;
  wb_t             wb_w;
  logic            e2w_valid;

  rv_idu i_idu (
    .inst_i      (inst_i),
    .pc_i        (pc_i),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .rs1_idx_o   (rs1_idx),
    .rs2_idx_o   (rs2_idx),
    .rs1_rd_en_o (rs1_rd_en),
    .rs2_rd_en_o (rs2_rd_en),
    .dec_o       (dec_d)
  );

  // unused read ports look at x0 and return zero
  rv_regfile i_regfile (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rs1_idx_i   (rs1_rd_en ? rs1_idx : 5'd0),
    .rs2_idx_i   (rs2_rd_en ? rs2_idx : 5'd0),
    .wr_en_i     (wb_wr_o),
    .wr_idx_i    (wb_w.rd),
    .wr_data_i   (wb_w.data),
    .fwd_i       (wb_e),
    .fwd_valid_i (d2e_valid),
    .rs1_data_o  (rs1_data),
    .rs2_data_o  (rs2_data)
  );

  rv_stage_reg #(.payload_t(dec_t)) d2e (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (redirect_o),
    .valid_i (inst_valid_i),
    .data_i  (dec_d),
    .valid_o (d2e_valid),
    .data_o  (dec_e)
  );

  rv_exu i_exu (
    .dec_i   (dec_e),
    .valid_i (d2e_valid),
    .wb_o    (wb_e)
  );

  // a redirect in W kills whatever D and E are holding
  rv_stage_reg #(.payload_t(wb_t)) e2w (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (redirect_o),
    .valid_i (d2e_valid),
    .data_i  (wb_e),
    .valid_o (e2w_valid),
    .data_o  (wb_w)
  );

  assign wb_valid_o    = e2w_valid;
  assign wb_rd_o       = wb_w.rd;
  assign wb_wr_o       = e2w_valid & wb_w.rd_wr;
  assign wb_data_o     = wb_w.data;
  assign redirect_o    = e2w_valid & wb_w.redirect;
  assign redirect_pc_o = wb_w.redirect_pc;
  assign ebreak_o      = e2w_valid & wb_w.ebreak;
  assign illegal_o     = e2w_valid & wb_w.illegal;

endmodule

`default_nettype wire

// File: rtl/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic [4:0]      rs1_idx_i,
  input  logic [4:0]      rs2_idx_i,
  input  logic            wr_en_i,
  input  logic [4:0]      wr_idx_i,
  input  logic [XLEN-1:0] wr_data_i,
  input  wb_t             fwd_i,
  input  logic            fwd_valid_i,
  output logic [XLEN-1:0] rs1_data_o,
  output logic [XLEN-1:0] rs2_data_o
);

  logic [XLEN-1:0] regs_q [NREG];
  logic            e_hit1;
  logic            e_hit2;
  logic            w_hit1;
  logic            w_hit2;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NREG; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // execute result is younger than writeback, so it wins
  assign e_hit1 = fwd_valid_i && fwd_i.rd_wr && (fwd_i.rd == rs1_idx_i);
  assign e_hit2 = fwd_valid_i && fwd_i.rd_wr && (fwd_i.rd == rs2_idx_i);
  assign w_hit1 = wr_en_i && (wr_idx_i == rs1_idx_i);
  assign w_hit2 = wr_en_i && (wr_idx_i == rs2_idx_i);

  assign rs1_data_o = e_hit1 ? fwd_i.data : (w_hit1 ? wr_data_i : regs_q[rs1_idx_i]);
  assign rs2_data_o = e_hit2 ? fwd_i.data : (w_hit2 ? wr_data_i : regs_q[rs2_idx_i]);

endmodule

`default_nettype wire

// File: rtl/rv_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // valid is cleared by reset or flush
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_i;
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// File: sim/rv_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert (
  input logic       clk_i,
  input logic       rst_i,
  input logic       wb_valid_i,
  input logic       redirect_i,
  input logic       ebreak_i,
  input logic       illegal_i,
  input logic       e2w_valid_i,
  input logic       wb_wr_i,
  input logic [4:0] wb_rd_i
);

  // covers every reset cycle and the one after it
  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i |=> !(wb_valid_i || redirect_i || ebreak_i || illegal_i))
    else $error("W stage flags active around reset");

  a_redirect_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    redirect_i |=> !redirect_i)
    else $error("redirect held for two cycles");

  a_redirect_flush: assert property (@(posedge clk_i) disable iff (rst_i)
    redirect_i |=> !e2w_valid_i)
    else $error("e2w valid after a redirect");

  a_no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_wr_i |-> wb_rd_i != 5'd0)
    else $error("register write to x0");

endmodule

bind rv_core_top rv_core_assert i_rv_core_assert (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .wb_valid_i  (wb_valid_o),
  .redirect_i  (redirect_o),
  .ebreak_i    (ebreak_o),
  .illegal_i   (illegal_o),
  .e2w_valid_i (e2w_valid),
  .wb_wr_i     (wb_wr_o),
  .wb_rd_i     (wb_rd_o)
);

`default_nettype wire

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

  typedef struct packed {
    logic            wr;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
    logic            redirect;
    logic [XLEN-1:0] rpc;
    logic            ebreak;
    logic            illegal;
  } rec_t;

  logic            clk;
  logic            rst;
  logic            inst_valid;
  logic [31:0]     inst;
  logic [XLEN-1:0] pc_in;
  logic            wb_valid;
  logic [4:0]      wb_rd;
  logic            wb_wr;
  logic [XLEN-1:0] wb_data;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;
  logic            ebreak;
  logic            illegal;

  integer          seed;
  logic [31:0]     prog [64];
  int              plen;
  logic [XLEN-1:0] fetch_pc;
  logic [XLEN-1:0] ref_regs [NREG];
  logic [XLEN-1:0] ref_next_pc;
  rec_t            exp_q [$];
  string           cur_test;
  int              checks;
  int              errors;
  time             deadline;

  rv_core_top i_rv_core_top (
    .clk_i         (clk),
    .rst_i         (rst),
    .inst_valid_i  (inst_valid),
    .inst_i        (inst),
    .pc_i          (pc_in),
    .wb_valid_o    (wb_valid),
    .wb_rd_o       (wb_rd),
    .wb_wr_o       (wb_wr),
    .wb_data_o     (wb_data),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .ebreak_o      (ebreak),
    .illegal_o     (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // ISA integer ops with alt picking sub and sra
  function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                               input logic [XLEN-1:0] x,
                                               input logic [XLEN-1:0] y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[5:0];
      3'd2:    return {63'b0, $signed(x) < $signed(y)};
      3'd3:    return {63'b0, x < y};
      3'd4:    return x ^ y;
      3'd5:    return alt ? 64'($signed(x) >>> y[5:0]) : x >> y[5:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  // executes one instruction and updates ref_regs and ref_next_pc
  function automatic rec_t ref_exec(input logic [31:0] in, input logic [XLEN-1:0] pc);
    rec_t            r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] ii;
    logic [XLEN-1:0] iu;
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] tgt;
    logic [2:0]      f3;
    logic            ok;
    logic            wr;
    logic            tk;
    r   = '0;
    a   = ref_regs[in[19:15]];
    b   = ref_regs[in[24:20]];
    ii  = {{52{in[31]}}, in[31:20]};
    iu  = {{32{in[31]}}, in[31:12], 12'b0};
    f3  = in[14:12];
    ok  = 1'b1;
    wr  = 1'b1;
    tk  = 1'b0;
    res = '0;
    tgt = '0;
    case (in[6:0])
      OPC_OP: begin
        ok  = in[31:25] == 7'h00 || (in[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        res = alu_ref(f3, in[30], a, b);
      end
      OPC_OP_IMM: begin
        if (f3 == 3'd1) begin
          ok = in[31:26] == 6'h00;
        end else if (f3 == 3'd5) begin
          ok = in[31:26] == 6'h00 || in[31:26] == 6'h10;
        end
        res = alu_ref(f3, f3 == 3'd5 && in[30], a, ii);
      end
      OPC_BRANCH: begin
        wr  = 1'b0;
        tgt = pc + {{51{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
        case (f3)
          3'd0:    tk = a == b;
          3'd1:    tk = a != b;
          3'd4:    tk = $signed(a) < $signed(b);
          3'd5:    tk = $signed(a) >= $signed(b);
          3'd6:    tk = a < b;
          3'd7:    tk = a >= b;
          default: ok = 1'b0;
        endcase
      end
      OPC_JAL: begin
        res = pc + 64'd4;
        tk  = 1'b1;
        tgt = pc + {{43{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
      end
      OPC_JALR: begin
        ok  = f3 == 3'd0;
        res = pc + 64'd4;
        tk  = 1'b1;
        tgt = (a + ii) & ~64'd1;
      end
      OPC_LUI:   res = iu;
      OPC_AUIPC: res = pc + iu;
      OPC_SYSTEM: begin
        ok       = in[31:7] == 25'h0002000;
        wr       = 1'b0;
        r.ebreak = ok;
      end
      default: ok = 1'b0;
    endcase
    r.illegal   = ~ok;
    r.wr        = ok && wr && in[11:7] != 5'd0;
    r.rd        = in[11:7];
    r.data      = res;
    r.redirect  = ok && tk;
    r.rpc       = tgt;
    ref_next_pc = r.redirect ? tgt : pc + 64'd4;
    if (r.wr) begin
      ref_regs[r.rd] = res;
    end
    return r;
  endfunction

  task automatic check(input string what, input logic [XLEN-1:0] exp,
                       input logic [XLEN-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  // writeback stream checked in program order
  always @(negedge clk) begin
    rec_t e;
    if (!rst && wb_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("test %s: the core wrote back an instruction that was not expected", cur_test);
      end else begin
        e = exp_q.pop_front();
        check("wr", 64'(e.wr), 64'(wb_wr));
        if (e.wr) begin
          check("rd", 64'(e.rd), 64'(wb_rd));
          check("data", e.data, wb_data);
        end
        check("redirect", 64'(e.redirect), 64'(redirect));
        if (e.redirect) begin
          check("redirect_pc", e.rpc, redirect_pc);
        end
        check("ebreak", 64'(e.ebreak), 64'(ebreak));
        check("illegal", 64'(e.illegal), 64'(illegal));
      end
    end
  end

  // reset phase only, each test sets its own limit
  initial begin
    deadline = time'(10 * 40);
    while ($time <= deadline) begin
      @(posedge clk);
    end
    $display("test %s: timed out waiting for writebacks", cur_test);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic add(input logic [31:0] word);
    prog[plen] = word;
    plen++;
  endtask

  // a redirect drops this slot and fetch resumes at the target next cycle
  task automatic drive_slot();
    @(negedge clk);
    if (redirect) begin
      fetch_pc   = redirect_pc;
      inst_valid = 1'b0;
    end else if (fetch_pc < 64'(plen * 4)) begin
      inst       = prog[fetch_pc[7:2]];
      pc_in      = fetch_pc;
      inst_valid = 1'b1;
      fetch_pc   = fetch_pc + 64'd4;
    end else begin
      inst_valid = 1'b0;
    end
  endtask

  task automatic run_test(input string name);
    logic [XLEN-1:0] p;
    int              c0;
    int              e0;
    int              guard;
    cur_test = name;
    c0       = checks;
    e0       = errors;
    p        = '0;
    guard    = 0;
    while (p < 64'(plen * 4) && guard < 4 * plen) begin
      exp_q.push_back(ref_exec(prog[p[7:2]], p));
      p = ref_next_pc;
      guard++;
    end
    deadline = $time + time'((4 * plen + 50) * 40);
    fetch_pc = '0;
    while (exp_q.size() != 0) begin
      drive_slot();
    end
    repeat (8) drive_slot();
    if (exp_q.size() != 0) begin
      errors++;
      $display("test %s: %0d writebacks never arrived", name, exp_q.size());
      exp_q.delete();
    end
    $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    plen = 0;
  endtask

  task automatic build_alu();
    logic [2:0]  f3;
    logic [11:0] imm;
    for (int r = 1; r < 16; r++) begin
      add({20'($random(seed)), 5'(r), OPC_LUI});
      add(enc_i(12'($random(seed)), 5'(r), 3'd0, 5'(r), OPC_OP_IMM));
    end
    add(enc_i(12'd63, 5'd1, 3'd1, 5'd16, OPC_OP_IMM));
    add(enc_i(12'h400, 5'd2, 3'd5, 5'd17, OPC_OP_IMM));
    for (int i = 0; i < 20; i++) begin
      f3 = 3'(rand_below(8));
      if (i % 2 == 0) begin
        add(enc_r(((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1) ? 7'h20 : 7'h00,
                  5'(1 + rand_below(15)), 5'(1 + rand_below(15)), f3,
                  5'(1 + rand_below(31))));
      end else begin
        if (f3 == 3'd1) begin
          imm = 12'(rand_below(64));
        end else if (f3 == 3'd5) begin
          imm = 12'(rand_below(64)) | (rand_below(2) == 1 ? 12'h400 : 12'h000);
        end else begin
          imm = 12'($random(seed));
        end
        add(enc_i(imm, 5'(1 + rand_below(15)), f3, 5'(1 + rand_below(31)), OPC_OP_IMM));
      end
    end
  endtask

  task automatic build_deps();
    logic [2:0] f3s [4];
    f3s = '{3'd0, 3'd4, 3'd6, 3'd7};
    // x10..x12 rotate, so each op reads the last two results
    for (int i = 0; i < 12; i++) begin
      add(enc_r((i % 3 == 0) ? 7'h20 : 7'h00, 5'(10 + (i + 1) % 3), 5'(10 + (i + 2) % 3),
                (i % 3 == 0) ? 3'd0 : f3s[rand_below(4)], 5'(10 + i % 3)));
    end
  endtask

  task automatic build_branch();
    logic [2:0] f3s [6];
    logic [4:0] rs1;
    logic [4:0] rs2;
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    // x1 negative and x2 positive so signed and unsigned order differ
    add(enc_i(12'h800 | 12'(rand_below(2048)), 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
    add(enc_i(12'(1 + rand_below(2047)), 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
    // each kind sees (x1, x2), (x2, x1) and (x1, x1)
    for (int k = 0; k < 18; k++) begin
      rs1 = (k / 6 == 1) ? 5'd2 : 5'd1;
      rs2 = (k / 6 == 0) ? 5'd2 : 5'd1;
      add(enc_b(13'd8, rs2, rs1, f3s[k % 6]));
      // skipped when the branch is taken
      add(enc_i(12'd1, 5'd20, 3'd0, 5'd20, OPC_OP_IMM));
    end
  endtask

  task automatic build_jump();
    add(enc_j(21'd8, 5'd1));
    add(enc_i(12'd1, 5'd20, 3'd0, 5'd20, OPC_OP_IMM));
    add(enc_i(12'd21, 5'd0, 3'd0, 5'd7, OPC_OP_IMM));
    add(enc_i(12'd0, 5'd7, 3'd0, 5'd2, OPC_JALR));
    add(enc_i(12'd1, 5'd20, 3'd0, 5'd20, OPC_OP_IMM));
    add(enc_i(12'd4, 5'd7, 3'd0, 5'd3, OPC_JALR));
    add(enc_i(12'd0, 5'd2, 3'd0, 5'd21, OPC_OP_IMM));
    add(enc_j(21'd8, 5'd0));
    add(enc_i(12'd1, 5'd20, 3'd0, 5'd20, OPC_OP_IMM));
    add(enc_r(7'h00, 5'd3, 5'd1, 3'd0, 5'd22));
  endtask

  task automatic build_upper();
    for (int k = 0; k < 4; k++) begin
      add({20'($random(seed)), 5'(24 + k), OPC_LUI});
      add({20'($random(seed)), 5'(28 + k), OPC_AUIPC});
    end
    add({20'($random(seed)), 5'd0, OPC_LUI});
    add(enc_i(12'd5, 5'd0, 3'd0, 5'd23, OPC_OP_IMM));
  endtask

  task automatic build_special();
    add(32'h0010_0073);
    add(enc_i(12'd1, 5'd24, 3'd0, 5'd25, OPC_OP_IMM));
    add(enc_i(12'd0, 5'd1, 3'd2, 5'd26, 7'b0000011));
    add(enc_i(12'd1, 5'd25, 3'd0, 5'd25, OPC_OP_IMM));
    add({7'd0, 5'd2, 5'd1, 3'b010, 5'd0, 7'b0100011});
    add(32'h0000_0073);
    add(32'h0000_007f);
    add(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd27));
    add(enc_i(12'd1, 5'd25, 3'd0, 5'd25, OPC_OP_IMM));
  endtask

  initial begin
    seed       = 32'h15ec_6bcc;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    pc_in      = '0;
    fetch_pc   = '0;
    plen       = 0;
    checks     = 0;
    errors     = 0;
    cur_test   = "reset";
    for (int i = 0; i < NREG; i++) begin
      ref_regs[i] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    build_alu();
    run_test("alu");
    build_deps();
    run_test("deps");
    build_branch();
    run_test("branch");
    build_jump();
    run_test("jump");
    build_upper();
    run_test("lui_auipc");
    build_special();
    run_test("special");
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
common/rv_pkg.sv
idu/rv_idu.sv
rtl/rv_regfile.sv
exu/rv_exu.sv
rtl/rv_stage_reg.sv
rtl/rv_core_top.sv
sim/rv_core_assert.sv
sim/tb_rv_core.sv
